// File: rtl/vdp_settings.svh
`ifndef VDP_SETTINGS_SVH
`define VDP_SETTINGS_SVH

// Horizontal raster of the 640x480 60 Hz mode in clocks
`define VDP_H_ACTIVE 640
`define VDP_H_FRONT 16
`define VDP_H_SYNC 96
`define VDP_H_BACK 48
`define VDP_H_TOTAL (`VDP_H_ACTIVE + `VDP_H_FRONT + `VDP_H_SYNC + `VDP_H_BACK)

// Vertical raster in lines
`define VDP_V_ACTIVE 480
`define VDP_V_FRONT 11
`define VDP_V_SYNC 2
`define VDP_V_BACK 31
`define VDP_V_TOTAL (`VDP_V_ACTIVE + `VDP_V_FRONT + `VDP_V_SYNC + `VDP_V_BACK)

// Backdrop around the 256x192 picture
// Left and right border in clocks and top and bottom border in lines
`define VDP_H_BORDER 64
`define VDP_V_BORDER 48

// Tile geometry
// One character cell is 8 pixels of 2 clocks each
`define VDP_CHARS_PER_ROW 32
`define VDP_CHAR_CLOCKS 16

// Length of the vertical retrace interrupt pulse in clocks
`define VDP_INT_CYCLES 64

`endif

// File: rtl/vdp_pkg.sv
package vdp_pkg;

  // Raster counters
  typedef logic [9:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // Picture x or y inside the 256x192 window
  typedef logic [7:0] pixel_coord_t;

  // Video RAM
  typedef logic [13:0] vram_addr_t;
  typedef logic [7:0] vram_data_t;

  // Palette index and 24-bit color with red in the top byte
  typedef logic [3:0] color_idx_t;
  typedef logic [23:0] rgb_t;

  // VRAM read sequence for one character
  typedef enum logic [2:0] {
    fetch_idle,
    fetch_name,
    fetch_pattern,
    fetch_color,
    fetch_load
  } fetch_state_t;

endpackage

// File: rtl/vdp_timing.sv
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_timing (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   vert_retrace_int,
  output logic                   hs_raw,
  output logic                   vs_raw,
  output logic                   de_raw,
  output logic                   border,
  output logic                   char_start,
  output logic                   n_int,
  output vdp_pkg::pixel_coord_t  pix_x,
  output vdp_pkg::pixel_coord_t  pix_y,
  output logic [2:0]             pix_in_char
);

  localparam int H_SYNC_START = `VDP_H_ACTIVE + `VDP_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `VDP_H_SYNC;
  localparam int V_SYNC_START = `VDP_V_ACTIVE + `VDP_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `VDP_V_SYNC;
  localparam int INT_CNT_W = $clog2(`VDP_INT_CYCLES);
  localparam logic [INT_CNT_W-1:0] INT_LAST = INT_CNT_W'(`VDP_INT_CYCLES - 1);

  vdp_pkg::hcount_t hc;
  vdp_pkg::vcount_t vc;
  logic int_active;
  logic [INT_CNT_W-1:0] int_cnt;

  // hc runs along the line and vc counts lines
  always_ff @(posedge clk) begin
    if (reset) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == `VDP_H_TOTAL - 1) begin
      hc <= '0;
      if (vc == `VDP_V_TOTAL - 1) begin
        vc <= '0;
      end else begin
        vc <= vc + 1'b1;
      end
    end else begin
      hc <= hc + 1'b1;
    end
  end

  // Retrace interrupt starts where vertical sync begins
  always_ff @(posedge clk) begin
    if (reset) begin
      int_active <= 1'b0;
      int_cnt <= '0;
    end else if (int_active) begin
      int_cnt <= int_cnt + 1'b1;
      if (int_cnt == INT_LAST) begin
        int_active <= 1'b0;
      end
    end else if (hc == H_SYNC_START && vc == V_SYNC_START && vert_retrace_int) begin
      int_active <= 1'b1;
      int_cnt <= '0;
    end
  end

  assign n_int = !int_active;

  assign de_raw = (hc < `VDP_H_ACTIVE) && (vc < `VDP_V_ACTIVE);
  assign hs_raw = !((hc >= H_SYNC_START) && (hc < H_SYNC_END));
  assign vs_raw = !((vc >= V_SYNC_START) && (vc < V_SYNC_END));

  assign border = (hc < `VDP_H_BORDER) || (hc >= `VDP_H_ACTIVE - `VDP_H_BORDER) ||
                  (vc < `VDP_V_BORDER) || (vc >= `VDP_V_ACTIVE - `VDP_V_BORDER);

  // Each picture pixel covers two clocks and two lines
  assign pix_x = vdp_pkg::pixel_coord_t'((hc >> 1) - (`VDP_H_BORDER / 2));
  assign pix_y = vdp_pkg::pixel_coord_t'((vc >> 1) - (`VDP_V_BORDER / 2));
  assign pix_in_char = pix_x[2:0];

  // High on the last clock of a character cell so the next cell starts on the following edge
  assign char_start = ((hc % `VDP_CHAR_CLOCKS) == (`VDP_CHAR_CLOCKS - 1)) &&
                      (hc < `VDP_H_ACTIVE);

endmodule

// File: rtl/vdp_fetch_ctrl.sv
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_fetch_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   video_on,
  input  logic                   char_start,
  input  vdp_pkg::pixel_coord_t  pix_x,
  input  vdp_pkg::pixel_coord_t  pix_y,
  input  vdp_pkg::vram_addr_t    name_table_addr,
  input  vdp_pkg::vram_addr_t    pattern_table_addr,
  input  vdp_pkg::vram_addr_t    color_table_addr,
  output vdp_pkg::vram_addr_t    disp_addr,
  input  vdp_pkg::vram_data_t    disp_data,
  output logic                   tile_load,
  output vdp_pkg::vram_data_t    pattern_byte,
  output vdp_pkg::vram_data_t    color_byte
);

  localparam int COL_W = $clog2(`VDP_CHARS_PER_ROW);
  // Cell being shown, then the one in the shifter's pending buffer, then this fetch
  localparam int FETCH_AHEAD = 2;

  vdp_pkg::fetch_state_t state;
  logic phase;
  logic [COL_W-1:0] col_q;
  logic [4:0] char_row;
  logic [2:0] line_in_char;
  vdp_pkg::vram_data_t name_q;
  vdp_pkg::vram_addr_t name_addr;
  vdp_pkg::vram_addr_t pattern_addr;
  vdp_pkg::vram_addr_t color_addr;

  assign char_row = pix_y[7:3];
  assign line_in_char = pix_y[2:0];

  // Table addresses for the character being fetched
  assign name_addr = vdp_pkg::vram_addr_t'(name_table_addr +
                     char_row * `VDP_CHARS_PER_ROW + col_q);
  assign pattern_addr = pattern_table_addr + vdp_pkg::vram_addr_t'({name_q, line_in_char});
  // One color byte covers 8 consecutive names
  assign color_addr = color_table_addr + vdp_pkg::vram_addr_t'(name_q >> 3);

  always_comb begin
    case (state)
      vdp_pkg::fetch_pattern: disp_addr = pattern_addr;
      vdp_pkg::fetch_color:   disp_addr = color_addr;
      default:                disp_addr = name_addr;
    endcase
  end

  // Each state lasts two clocks and the VRAM data arrives in the second one
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= vdp_pkg::fetch_idle;
      phase <= 1'b0;
    end else begin
      case (state)
        vdp_pkg::fetch_idle: begin
          if (char_start && video_on) begin
            state <= vdp_pkg::fetch_name;
          end
        end
        vdp_pkg::fetch_name: begin
          phase <= !phase;
          if (phase) begin
            state <= vdp_pkg::fetch_pattern;
          end
        end
        vdp_pkg::fetch_pattern: begin
          phase <= !phase;
          if (phase) begin
            state <= vdp_pkg::fetch_color;
          end
        end
        vdp_pkg::fetch_color: begin
          phase <= !phase;
          if (phase) begin
            state <= vdp_pkg::fetch_load;
          end
        end
        default: begin
          phase <= !phase;
          if (phase) begin
            state <= vdp_pkg::fetch_idle;
          end
        end
      endcase
    end
  end

  // Column is sampled once so the name address holds while pix_x moves on
  always_ff @(posedge clk) begin
    if (char_start) begin
      col_q <= COL_W'(pix_x[7:3] + FETCH_AHEAD);
    end
    if (phase) begin
      if (state == vdp_pkg::fetch_name) begin
        name_q <= disp_data;
      end else if (state == vdp_pkg::fetch_pattern) begin
        pattern_byte <= disp_data;
      end else if (state == vdp_pkg::fetch_color) begin
        color_byte <= disp_data;
      end
    end
  end

  assign tile_load = (state == vdp_pkg::fetch_load) && !phase;

endmodule

// File: rtl/vdp_vram.sv
`timescale 1ns/100ps

module vdp_vram (
  input  logic                 clk,
  input  vdp_pkg::vram_addr_t  cpu_addr,
  input  vdp_pkg::vram_data_t  cpu_wdata,
  input  logic                 cpu_we,
  input  logic                 cpu_re,
  output vdp_pkg::vram_data_t  cpu_rdata,
  input  vdp_pkg::vram_addr_t  disp_addr,
  output vdp_pkg::vram_data_t  disp_data
);

  localparam int DEPTH = 1 << $bits(vdp_pkg::vram_addr_t);

  vdp_pkg::vram_data_t mem [DEPTH];

  // CPU port
  // A read in the same clock as a write to that address returns the old byte
  always_ff @(posedge clk) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    if (cpu_re) begin
      cpu_rdata <= mem[cpu_addr];
    end
  end

  // Display port, read every clock
  always_ff @(posedge clk) begin
    disp_data <= mem[disp_addr];
  end

endmodule

// File: rtl/vdp_tile_shifter.sv
`timescale 1ns/100ps

module vdp_tile_shifter (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tile_load,
  input  logic                 char_start,
  input  vdp_pkg::vram_data_t  pattern_byte,
  input  vdp_pkg::vram_data_t  color_byte,
  input  logic [2:0]           pix_in_char,
  output vdp_pkg::color_idx_t  tile_color
);

  // Next character, filled by the fetch
  vdp_pkg::vram_data_t pattern_next;
  vdp_pkg::vram_data_t color_next;

  // Character on screen now
  vdp_pkg::vram_data_t pattern_cur;
  vdp_pkg::vram_data_t color_cur;

  always_ff @(posedge clk) begin
    if (reset) begin
      pattern_next <= '0;
      color_next <= '0;
      pattern_cur <= '0;
      color_cur <= '0;
    end else begin
      if (tile_load) begin
        pattern_next <= pattern_byte;
        color_next <= color_byte;
      end
      if (char_start) begin
        pattern_cur <= pattern_next;
        color_cur <= color_next;
      end
    end
  end

  // Bit 7 is the leftmost pixel and a set bit takes the high nibble
  assign tile_color = pattern_cur[~pix_in_char] ? color_cur[7:4] : color_cur[3:0];

endmodule

// File: rtl/vdp_palette.sv
`timescale 1ns/100ps

module vdp_palette (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 hs_raw,
  input  logic                 vs_raw,
  input  logic                 de_raw,
  input  logic                 border,
  input  logic                 video_on,
  input  vdp_pkg::color_idx_t  back_color,
  input  vdp_pkg::color_idx_t  tile_color,
  output logic [7:0]           vga_r,
  output logic [7:0]           vga_g,
  output logic [7:0]           vga_b,
  output logic                 vga_hs,
  output logic                 vga_vs,
  output logic                 vga_de
);

  vdp_pkg::color_idx_t pixel_idx;
  vdp_pkg::rgb_t pixel_rgb;

  // Fixed MSX palette
  function automatic vdp_pkg::rgb_t msx_color(input vdp_pkg::color_idx_t idx);
    case (idx)
      4'd0:    msx_color = 24'h000000;
      4'd1:    msx_color = 24'h010101;
      4'd2:    msx_color = 24'h3eb849;
      4'd3:    msx_color = 24'h74d07d;
      4'd4:    msx_color = 24'h5955e0;
      4'd5:    msx_color = 24'h8076f1;
      4'd6:    msx_color = 24'h993e31;
      4'd7:    msx_color = 24'h65dbef;
      4'd8:    msx_color = 24'hdb6559;
      4'd9:    msx_color = 24'hff897d;
      4'd10:   msx_color = 24'hccc35e;
      4'd11:   msx_color = 24'hded087;
      4'd12:   msx_color = 24'h3aa241;
      4'd13:   msx_color = 24'hb766b5;
      4'd14:   msx_color = 24'h777777;
      default: msx_color = 24'hffffff;
    endcase
  endfunction

  // Index 0 is transparent and lets the backdrop through
  assign pixel_idx = (border || !video_on || tile_color == '0) ? back_color : tile_color;
  assign pixel_rgb = msx_color(pixel_idx);

  always_ff @(posedge clk) begin
    if (reset) begin
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_de <= 1'b0;
      {vga_r, vga_g, vga_b} <= '0;
    end else begin
      vga_hs <= hs_raw;
      vga_vs <= vs_raw;
      vga_de <= de_raw;
      {vga_r, vga_g, vga_b} <= de_raw ? pixel_rgb : '0;
    end
  end

endmodule

// File: rtl/vdp_video.sv
`timescale 1ns/100ps

module vdp_video (
  input  logic                 clk,
  input  logic                 reset,
  input  vdp_pkg::vram_addr_t  vram_addr,
  input  vdp_pkg::vram_data_t  vram_wdata,
  input  logic                 vram_we,
  input  logic                 vram_re,
  output vdp_pkg::vram_data_t  vram_rdata,
  input  vdp_pkg::vram_addr_t  name_table_addr,
  input  vdp_pkg::vram_addr_t  pattern_table_addr,
  input  vdp_pkg::vram_addr_t  color_table_addr,
  input  vdp_pkg::color_idx_t  back_color,
  input  logic                 video_on,
  input  logic                 vert_retrace_int,
  output logic [7:0]           vga_r,
  output logic [7:0]           vga_g,
  output logic [7:0]           vga_b,
  output logic                 vga_hs,
  output logic                 vga_vs,
  output logic                 vga_de,
  output logic                 n_int
);

  // Raster decode
  logic hs_raw;
  logic vs_raw;
  logic de_raw;
  logic border;
  logic char_start;
  vdp_pkg::pixel_coord_t pix_x;
  vdp_pkg::pixel_coord_t pix_y;
  logic [2:0] pix_in_char;

  // Display read port of the VRAM
  vdp_pkg::vram_addr_t disp_addr;
  vdp_pkg::vram_data_t disp_data;

  // Fetched character data
  logic tile_load;
  vdp_pkg::vram_data_t pattern_byte;
  vdp_pkg::vram_data_t color_byte;
  vdp_pkg::color_idx_t tile_color;

  vdp_timing u_timing (
    .clk              (clk),
    .reset            (reset),
    .vert_retrace_int (vert_retrace_int),
    .hs_raw           (hs_raw),
    .vs_raw           (vs_raw),
    .de_raw           (de_raw),
    .border           (border),
    .char_start       (char_start),
    .n_int            (n_int),
    .pix_x            (pix_x),
    .pix_y            (pix_y),
    .pix_in_char      (pix_in_char)
  );

  vdp_fetch_ctrl u_fetch_ctrl (
    .clk                (clk),
    .reset              (reset),
    .video_on           (video_on),
    .char_start         (char_start),
    .pix_x              (pix_x),
    .pix_y              (pix_y),
    .name_table_addr    (name_table_addr),
    .pattern_table_addr (pattern_table_addr),
    .color_table_addr   (color_table_addr),
    .disp_addr          (disp_addr),
    .disp_data          (disp_data),
    .tile_load          (tile_load),
    .pattern_byte       (pattern_byte),
    .color_byte         (color_byte)
  );

  vdp_vram u_vram (
    .clk       (clk),
    .cpu_addr  (vram_addr),
    .cpu_wdata (vram_wdata),
    .cpu_we    (vram_we),
    .cpu_re    (vram_re),
    .cpu_rdata (vram_rdata),
    .disp_addr (disp_addr),
    .disp_data (disp_data)
  );

  vdp_tile_shifter u_tile_shifter (
    .clk          (clk),
    .reset        (reset),
    .tile_load    (tile_load),
    .char_start   (char_start),
    .pattern_byte (pattern_byte),
    .color_byte   (color_byte),
    .pix_in_char  (pix_in_char),
    .tile_color   (tile_color)
  );

  vdp_palette u_palette (
    .clk        (clk),
    .reset      (reset),
    .hs_raw     (hs_raw),
    .vs_raw     (vs_raw),
    .de_raw     (de_raw),
    .border     (border),
    .video_on   (video_on),
    .back_color (back_color),
    .tile_color (tile_color),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b),
    .vga_hs     (vga_hs),
    .vga_vs     (vga_vs),
    .vga_de     (vga_de)
  );

endmodule

// File: verification/vdp_video_properties.sv
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_video_properties (
  input logic       clk,
  input logic       reset,
  input logic [7:0] vga_r,
  input logic [7:0] vga_g,
  input logic [7:0] vga_b,
  input logic       vga_hs,
  input logic       vga_vs,
  input logic       vga_de,
  input logic       n_int
);

  int failures = 0;
  int de_run;
  int since_de;
  int hs_low;
  int int_low;
  int de_lines;
  logic de_q;
  logic vs_q;

  // Lengths of the output levels as counted on the sampled values
  always_ff @(posedge clk) begin
    if (reset) begin
      de_run <= 0;
      since_de <= 0;
      hs_low <= 0;
      int_low <= 0;
      de_lines <= 0;
      de_q <= 1'b0;
      vs_q <= 1'b1;
    end else begin
      de_q <= vga_de;
      vs_q <= vga_vs;
      de_run <= vga_de ? de_run + 1 : 0;
      since_de <= vga_de ? 0 : since_de + 1;
      hs_low <= vga_hs ? 0 : hs_low + 1;
      int_low <= n_int ? 0 : int_low + 1;
      // Lines with de since the last vertical sync
      if (!vga_vs && vs_q) begin
        de_lines <= 0;
      end else if (vga_de && !de_q) begin
        de_lines <= de_lines + 1;
      end
    end
  end

  a_de_run: assert property (@(posedge clk) disable iff (reset)
    $fell(vga_de) |-> de_run == `VDP_H_ACTIVE)
    else begin
      $error("de run is not one full active line");
      failures++;
    end

  a_de_lines: assert property (@(posedge clk) disable iff (reset)
    $fell(vga_vs) |-> de_lines == `VDP_V_ACTIVE)
    else begin
      $error("frame does not hold the active line count");
      failures++;
    end

  // Blanking lines have no de, so their hsync is far from the last de clock
  a_hs_start: assert property (@(posedge clk) disable iff (reset)
    $fell(vga_hs) |-> since_de == `VDP_H_FRONT || since_de >= `VDP_H_TOTAL)
    else begin
      $error("hsync does not start one front porch after de");
      failures++;
    end

  a_hs_width: assert property (@(posedge clk) disable iff (reset)
    $rose(vga_hs) |-> hs_low == `VDP_H_SYNC)
    else begin
      $error("hsync pulse has the wrong width");
      failures++;
    end

  a_blank_black: assert property (@(posedge clk) disable iff (reset)
    !vga_de |-> {vga_r, vga_g, vga_b} == '0)
    else begin
      $error("rgb is not black outside de");
      failures++;
    end

  a_int_width: assert property (@(posedge clk) disable iff (reset)
    $rose(n_int) |-> int_low == `VDP_INT_CYCLES)
    else begin
      $error("interrupt pulse has the wrong length");
      failures++;
    end

  // Interrupt starts with the hsync of the first vsync line
  a_int_start: assert property (@(posedge clk) disable iff (reset)
    $fell(n_int) |-> !vga_vs && $fell(vga_hs))
    else begin
      $error("interrupt does not start at vertical retrace");
      failures++;
    end

endmodule

bind vdp_video vdp_video_properties props (
  .clk    (clk),
  .reset  (reset),
  .vga_r  (vga_r),
  .vga_g  (vga_g),
  .vga_b  (vga_b),
  .vga_hs (vga_hs),
  .vga_vs (vga_vs),
  .vga_de (vga_de),
  .n_int  (n_int)
);

// File: verification/tb_vdp_video.sv
`timescale 1ns/100ps
`include "vdp_settings.svh"

module tb_vdp_video;

  localparam vdp_pkg::vram_addr_t NAME_BASE = 14'h1800;
  localparam vdp_pkg::vram_addr_t PATTERN_BASE = 14'h0000;
  localparam vdp_pkg::vram_addr_t COLOR_BASE = 14'h2000;
  localparam vdp_pkg::color_idx_t BACK_COLOR = 4'd4;
  localparam int FRAME_CLOCKS = `VDP_H_TOTAL * `VDP_V_TOTAL;

  // MSX palette in index order
  localparam vdp_pkg::rgb_t MSX_RGB [16] = '{
    24'h000000, 24'h010101, 24'h3eb849, 24'h74d07d,
    24'h5955e0, 24'h8076f1, 24'h993e31, 24'h65dbef,
    24'hdb6559, 24'hff897d, 24'hccc35e, 24'hded087,
    24'h3aa241, 24'hb766b5, 24'h777777, 24'hffffff
  };

  logic clk;
  logic reset;
  vdp_pkg::vram_addr_t vram_addr;
  vdp_pkg::vram_data_t vram_wdata;
  logic vram_we;
  logic vram_re;
  vdp_pkg::vram_data_t vram_rdata;
  vdp_pkg::vram_addr_t name_table_addr;
  vdp_pkg::vram_addr_t pattern_table_addr;
  vdp_pkg::vram_addr_t color_table_addr;
  vdp_pkg::color_idx_t back_color;
  logic video_on;
  logic vert_retrace_int;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic vga_hs;
  logic vga_vs;
  logic vga_de;
  logic n_int;

  vdp_pkg::vram_data_t vram_model [16384];
  vdp_pkg::vram_addr_t written [$];
  logic [15:0] lfsr_state;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  bit timed_out = 1'b0;

  vdp_video uut (.*);

  always #50 clk = ~clk;

  // One clock, then a settle delay where outputs are read and inputs driven
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_byte(output vdp_pkg::vram_data_t value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
  endtask

  task automatic report_timeout(input string reason);
    timed_out = 1'b1;
    $display("Error at %0t: %s", $time, reason);
  endtask

  task automatic finish_test(input string name, input int bad);
    tests_run++;
    if (bad == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, bad);
    end
  endtask

  task automatic fill_table(input vdp_pkg::vram_addr_t base, input int count);
    vdp_pkg::vram_data_t data;
    for (int i = 0; i < count; i++) begin
      random_byte(data);
      vram_addr = vdp_pkg::vram_addr_t'(base + i);
      vram_wdata = data;
      vram_we = 1'b1;
      vram_model[vram_addr] = data;
      written.push_back(vram_addr);
      tick();
    end
    vram_we = 1'b0;
  endtask

  task automatic read_check(input vdp_pkg::vram_addr_t addr);
    vram_addr = addr;
    vram_re = 1'b1;
    tick();
    vram_re = 1'b0;
    assert (vram_rdata == vram_model[addr]) else begin
      report_mismatch("vram_rdata", vram_model[addr], vram_rdata);
    end
  endtask

  // Pixel at de count x on de line y of the frame
  function automatic vdp_pkg::rgb_t expected_rgb(input int x, input int y);
    int px;
    int py;
    vdp_pkg::vram_data_t name;
    vdp_pkg::vram_data_t pattern;
    vdp_pkg::vram_data_t color;
    vdp_pkg::color_idx_t idx;
    idx = back_color;
    if (video_on && x >= `VDP_H_BORDER && x < `VDP_H_ACTIVE - `VDP_H_BORDER &&
        y >= `VDP_V_BORDER && y < `VDP_V_ACTIVE - `VDP_V_BORDER) begin
      px = (x - `VDP_H_BORDER) / 2;
      py = (y - `VDP_V_BORDER) / 2;
      name = vram_model[NAME_BASE + (py / 8) * `VDP_CHARS_PER_ROW + px / 8];
      pattern = vram_model[PATTERN_BASE + name * 8 + py % 8];
      color = vram_model[COLOR_BASE + name / 8];
      idx = pattern[7 - px % 8] ? color[7:4] : color[3:0];
      if (idx == 4'd0) begin
        idx = back_color;
      end
    end
    return MSX_RGB[idx];
  endfunction

  task automatic wait_vs_fall();
    logic prev_vs;
    bit seen;
    prev_vs = vga_vs;
    seen = 1'b0;
    for (int cycle = 0; cycle < FRAME_CLOCKS + 100 && !seen && !timed_out; cycle++) begin
      tick();
      seen = !vga_vs && prev_vs;
      prev_vs = vga_vs;
    end
    if (!seen && !timed_out) begin
      report_timeout("vga_vs did not fall within one frame");
    end
  endtask

  // Walks one frame from vsync to vsync, checking every de pixel
  task automatic scan_frame(output int raster_bad, output int pixel_bad,
                            output int int_falls, output int int_low);
    int run;
    int line;
    logic prev_de;
    logic prev_vs;
    logic prev_int;
    bit done;
    vdp_pkg::rgb_t expected;
    raster_bad = 0;
    pixel_bad = 0;
    int_falls = 0;
    int_low = 0;
    run = 0;
    line = 0;
    done = 1'b0;
    wait_vs_fall();
    prev_de = vga_de;
    prev_vs = vga_vs;
    prev_int = n_int;
    for (int cycle = 0; cycle < FRAME_CLOCKS + 100 && !done && !timed_out; cycle++) begin
      tick();
      if (vga_de) begin
        expected = expected_rgb(run, line);
        assert ({vga_r, vga_g, vga_b} == expected) else begin
          report_mismatch("vga_r/vga_g/vga_b", expected, {vga_r, vga_g, vga_b});
          pixel_bad++;
        end
        run++;
      end else if (prev_de) begin
        assert (run == `VDP_H_ACTIVE) else begin
          report_mismatch("vga_de run length", `VDP_H_ACTIVE, run);
          raster_bad++;
        end
        run = 0;
        line++;
      end
      if (!n_int) begin
        int_low++;
      end
      if (!n_int && prev_int) begin
        int_falls++;
      end
      done = !vga_vs && prev_vs;
      prev_de = vga_de;
      prev_vs = vga_vs;
      prev_int = n_int;
    end
    if (!done && !timed_out) begin
      report_timeout("vga_vs did not fall again within one frame");
    end
    if (!done) begin
      raster_bad++;
    end else begin
      assert (line == `VDP_V_ACTIVE) else begin
        report_mismatch("vga_de lines per frame", `VDP_V_ACTIVE, line);
        raster_bad++;
      end
    end
  endtask

  initial begin
    int bad;
    int raster_bad;
    int pixel_bad;
    int int_falls;
    int int_low;
    clk = 1'b0;
    reset = 1'b1;
    vram_addr = '0;
    vram_wdata = '0;
    vram_we = 1'b0;
    vram_re = 1'b0;
    name_table_addr = NAME_BASE;
    pattern_table_addr = PATTERN_BASE;
    color_table_addr = COLOR_BASE;
    back_color = BACK_COLOR;
    video_on = 1'b0;
    vert_retrace_int = 1'b0;
    lfsr_state = 16'd83;
    repeat (4) tick();
    reset = 1'b0;

    // Tables are loaded while the display is off
    bad = errors;
    fill_table(NAME_BASE, 768);
    fill_table(PATTERN_BASE, 2048);
    fill_table(COLOR_BASE, 32);
    foreach (written[i]) begin
      read_check(written[i]);
    end
    finish_test("cpu read-back", errors - bad);

    video_on = 1'b1;
    vert_retrace_int = 1'b1;
    scan_frame(raster_bad, pixel_bad, int_falls, int_low);
    finish_test("raster timing with video on", raster_bad);
    finish_test("tile pixels and border", pixel_bad);
    bad = errors;
    assert (int_falls == 1) else report_mismatch("n_int falls per frame", 1, int_falls);
    assert (int_low == `VDP_INT_CYCLES) else begin
      report_mismatch("n_int low clocks", `VDP_INT_CYCLES, int_low);
    end
    finish_test("interrupt pulse", errors - bad);

    // The shifter still holds the last fetched character once the display is off
    video_on = 1'b0;
    vert_retrace_int = 1'b0;
    scan_frame(raster_bad, pixel_bad, int_falls, int_low);
    finish_test("raster timing with video off", raster_bad);
    finish_test("backdrop with video off", pixel_bad);
    bad = errors;
    assert (int_falls == 0) else report_mismatch("n_int falls per frame", 0, int_falls);
    assert (int_low == 0) else report_mismatch("n_int low clocks", 0, int_low);
    finish_test("interrupt disabled", errors - bad);

    $display("%0d tests, %0d failed, %0d mismatches, %0d property failures",
             tests_run, tests_failed, errors, uut.props.failures);
    if (tests_failed == 0 && uut.props.failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/vdp_pkg.sv
rtl/vdp_timing.sv
rtl/vdp_fetch_ctrl.sv
rtl/vdp_vram.sv
rtl/vdp_tile_shifter.sv
rtl/vdp_palette.sv
rtl/vdp_video.sv
verification/vdp_video_properties.sv
verification/tb_vdp_video.sv

// File: Makefile
# Verilator build and run of the VDP display path testbench

TOP = tb_vdp_video

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > run.log 2>&1; cat run.log
	grep -q "all tests passed" run.log

clean:
	rm -rf obj_dir run.log
